// ==== common/attack_cfg.svh ====
`ifndef ATTACK_CFG_SVH
`define ATTACK_CFG_SVH

// Active cycles per attack class
`define SMASH_CYCLES   16
`define JAB_CYCLES     8
`define SPECIAL_CYCLES 24

// Knockback words, X in upper half and Y in lower half
`define KB_SMASH_U 32'h00000800
`define KB_SMASH_D 32'h0000F7FE
// Pushes left with a small upward lift
`define KB_SMASH_L 32'hF7FE00E0
// Pushes right with the same lift
`define KB_SMASH_R 32'h080000E0

// Upward step while special up runs
`define MOVE_SPECIAL_U 32'h00000010

`endif

// ==== common/attack_pkg.sv ====
package attack_pkg;

	// Screen coordinate or extent
	typedef logic [15:0] coord_t;

	// Packed X/Y word, also used for status and effect outputs
	typedef logic [31:0] word_t;

	// Attack id, zero for none
	typedef logic [3:0] attack_code_t;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		RECOVER
	} seq_state_t;

	// Codes match the status bit each attack raises
	localparam attack_code_t ATK_SMASH_U   = 4'd1;
	localparam attack_code_t ATK_SMASH_D   = 4'd2;
	localparam attack_code_t ATK_SMASH_L   = 4'd3;
	localparam attack_code_t ATK_SMASH_R   = 4'd4;
	localparam attack_code_t ATK_JAB       = 4'd5;
	localparam attack_code_t ATK_SPECIAL_U = 4'd6;
	localparam attack_code_t ATK_SPECIAL_D = 4'd7;
	localparam attack_code_t ATK_SPECIAL_L = 4'd8;
	localparam attack_code_t ATK_SPECIAL_R = 4'd9;
	// Neutral special, direction from facing
	localparam attack_code_t ATK_SPECIAL_N = 4'd10;

endpackage

// ==== common/hitbox_if.sv ====
`timescale 1ns/1ps

interface hitbox_if;
	import attack_pkg::*;

	// Box origin
	coord_t x;
	coord_t y;
	// Box extent
	coord_t w;
	coord_t h;

	// Driven by hitbox construction
	modport source (output x, output y, output w, output h);

	// Read by the overlap test
	modport check (input x, input y, input w, input h);

endinterface

// ==== hw/input_decoder.sv ====
`timescale 1ns/1ps

module input_decoder (
	input  logic                     clock,
	input  logic                     rst_n,
	input  attack_pkg::word_t        controls,
	output logic                     req_valid,
	output attack_pkg::attack_code_t req_code,
	output logic                     req_facing
);
	import attack_pkg::*;

	logic smash_l, smash_r, smash_u, smash_d;
	logic btn_a, btn_b, facing_r;
	logic tilt_l, tilt_r, tilt_u, tilt_d;
	attack_code_t code_next;

	// Smash triggers
	assign smash_l = controls[23];
	assign smash_r = controls[22];
	assign smash_u = controls[21];
	assign smash_d = controls[20];

	// Buttons and facing
	assign btn_a    = controls[16];
	assign btn_b    = controls[17];
	assign facing_r = controls[26];

	// Stick X all zero is left, all one is right
	assign tilt_l = (controls[15:13] == 3'b000);
	assign tilt_r = (controls[15:13] == 3'b111);
	// Stick Y all one is up, all zero is down
	assign tilt_u = (controls[7:5] == 3'b111);
	assign tilt_d = (controls[7:5] == 3'b000);

	// Priority resolve
	always_comb begin
		code_next = '0;
		if (smash_l)
			code_next = ATK_SMASH_L;
		else if (smash_r)
			code_next = ATK_SMASH_R;
		else if (smash_u)
			code_next = ATK_SMASH_U;
		else if (smash_d)
			code_next = ATK_SMASH_D;
		else if (btn_a)
			code_next = ATK_JAB;
		else if (btn_b) begin
			// Tilts checked L, R, U, D
			if (tilt_l)
				code_next = ATK_SPECIAL_L;
			else if (tilt_r)
				code_next = ATK_SPECIAL_R;
			else if (tilt_u)
				code_next = ATK_SPECIAL_U;
			else if (tilt_d)
				code_next = ATK_SPECIAL_D;
			else
				code_next = ATK_SPECIAL_N;
		end
	end

	// One request per cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			req_valid  <= 1'b0;
			req_code   <= '0;
			req_facing <= 1'b0;
		end else begin
			req_valid  <= (code_next != '0);
			req_code   <= code_next;
			req_facing <= facing_r;
		end
	end

endmodule

// ==== attack/attack_sequencer.sv ====
`timescale 1ns/1ps
`include "attack_cfg.svh"

module attack_sequencer (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     req_valid,
	input  attack_pkg::attack_code_t req_code,
	input  logic                     req_facing,
	input  logic                     hit,
	output attack_pkg::attack_code_t active_code,
	output logic                     active_facing,
	output logic                     strike,
	output attack_pkg::word_t        attack
);
	import attack_pkg::*;

	// Longest duration sets counter width
	localparam int MAX_CYCLES = (`SMASH_CYCLES > `JAB_CYCLES) ?
		((`SMASH_CYCLES > `SPECIAL_CYCLES) ? `SMASH_CYCLES : `SPECIAL_CYCLES) :
		((`JAB_CYCLES > `SPECIAL_CYCLES) ? `JAB_CYCLES : `SPECIAL_CYCLES);
	localparam int CNT_W = (MAX_CYCLES > 1) ? $clog2(MAX_CYCLES) : 1;

	seq_state_t       state_q;
	logic [CNT_W-1:0] cnt_q;
	attack_code_t     code_q;
	logic             facing_q;
	logic [11:1]      status_q;
	word_t            code_bit;

	// Counter preload, one less than active cycles
	function automatic logic [CNT_W-1:0] load_count(input attack_code_t code);
		logic [CNT_W-1:0] n;
		case (code)
			ATK_SMASH_U, ATK_SMASH_D, ATK_SMASH_L, ATK_SMASH_R:
				n = CNT_W'(`SMASH_CYCLES - 1);
			ATK_JAB:
				n = CNT_W'(`JAB_CYCLES - 1);
			default:
				n = CNT_W'(`SPECIAL_CYCLES - 1);
		endcase
		return n;
	endfunction

	// Status bit position equals the code
	assign code_bit = word_t'(1) << req_code;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= IDLE;
			cnt_q    <= '0;
			code_q   <= '0;
			facing_q <= 1'b0;
			status_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					// Requests outside IDLE are simply dropped
					if (req_valid) begin
						state_q  <= ACTIVE;
						cnt_q    <= load_count(req_code);
						code_q   <= req_code;
						facing_q <= req_facing;
						status_q <= {1'b1, code_bit[10:1]};
					end
				end
				ACTIVE: begin
					if (cnt_q == '0) begin
						state_q  <= RECOVER;
						status_q <= '0;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				// Single dead cycle before the next attack
				RECOVER: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Code only visible while active
	assign active_code   = (state_q == ACTIVE) ? code_q : '0;
	assign active_facing = facing_q;
	assign strike        = (state_q == ACTIVE) & hit;

	// Bit 0 follows the live hit
	assign attack = {20'b0, status_q, status_q[11] & hit};

endmodule

// ==== attack/hitbox_gen.sv ====
`timescale 1ns/1ps

module hitbox_gen (
	input  attack_pkg::word_t        char1_pos,
	input  attack_pkg::word_t        char1_size,
	input  attack_pkg::attack_code_t active_code,
	input  logic                     active_facing,
	hitbox_if.source                 box
);
	import attack_pkg::*;

	localparam logic [1:0] DIR_L = 2'd0;
	localparam logic [1:0] DIR_R = 2'd1;
	localparam logic [1:0] DIR_U = 2'd2;
	localparam logic [1:0] DIR_D = 2'd3;

	coord_t px, py, wd, ht;
	coord_t hw, hh;
	logic [1:0] dir;

	// Attacker box fields
	assign px = char1_pos[31:16];
	assign py = char1_pos[15:0];
	assign wd = char1_size[31:16];
	assign ht = char1_size[15:0];

	// Half extents, rounded down
	assign hw = wd >> 1;
	assign hh = ht >> 1;

	// Direction from code
	always_comb begin
		case (active_code)
			ATK_SMASH_U, ATK_SPECIAL_U: dir = DIR_U;
			ATK_SMASH_D, ATK_SPECIAL_D: dir = DIR_D;
			ATK_SMASH_L, ATK_SPECIAL_L: dir = DIR_L;
			ATK_SMASH_R, ATK_SPECIAL_R: dir = DIR_R;
			// Jab and neutral special use facing
			default: dir = active_facing ? DIR_R : DIR_L;
		endcase
	end

	// Origin per direction, wraps at 16 bits
	always_comb begin
		case (dir)
			DIR_L: begin
				box.x = px - hw;
				box.y = py + (hh >> 1);
			end
			DIR_R: begin
				box.x = px + wd;
				box.y = py + (hh >> 1);
			end
			DIR_U: begin
				box.x = px + (hw >> 1);
				box.y = py + ht;
			end
			default: begin
				box.x = px + (hw >> 1);
				box.y = py - (hh >> 1);
			end
		endcase
	end

	// Size is fixed at half by half
	assign box.w = hw;
	assign box.h = hh;

endmodule

// ==== attack/box_overlap.sv ====
`timescale 1ns/1ps

module box_overlap (
	hitbox_if.check           box,
	input  attack_pkg::word_t char2_pos,
	input  attack_pkg::word_t char2_size,
	output logic              hit
);
	import attack_pkg::*;

	coord_t ox, oy, ow, oh;
	logic [16:0] hb_x_end, hb_y_end;
	logic [16:0] op_x_end, op_y_end;
	logic ov_x, ov_y;

	// Opponent box fields
	assign ox = char2_pos[31:16];
	assign oy = char2_pos[15:0];
	assign ow = char2_size[31:16];
	assign oh = char2_size[15:0];

	// Far edges keep the carry so nothing wraps
	assign hb_x_end = {1'b0, box.x} + {1'b0, box.w};
	assign hb_y_end = {1'b0, box.y} + {1'b0, box.h};
	assign op_x_end = {1'b0, ox} + {1'b0, ow};
	assign op_y_end = {1'b0, oy} + {1'b0, oh};

	// Half-open interval overlap per axis
	assign ov_x = ({1'b0, box.x} < op_x_end) && ({1'b0, ox} < hb_x_end);
	assign ov_y = ({1'b0, box.y} < op_y_end) && ({1'b0, oy} < hb_y_end);

	assign hit = ov_x & ov_y;

endmodule

// ==== hw/effect_unit.sv ====
`timescale 1ns/1ps
`include "attack_cfg.svh"

module effect_unit (
	input  logic                     clock,
	input  logic                     rst_n,
	input  attack_pkg::attack_code_t active_code,
	input  logic                     strike,
	output attack_pkg::word_t        knockback,
	output attack_pkg::word_t        movement
);
	import attack_pkg::*;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			knockback <= '0;
			movement  <= '0;
		end else begin
			// Only landed smashes change knockback
			if (strike) begin
				case (active_code)
					ATK_SMASH_U: knockback <= `KB_SMASH_U;
					ATK_SMASH_D: knockback <= `KB_SMASH_D;
					ATK_SMASH_L: knockback <= `KB_SMASH_L;
					ATK_SMASH_R: knockback <= `KB_SMASH_R;
					// Others hold the last value
					default: knockback <= knockback;
				endcase
			end
			// Step up each active cycle of special up, hit or not
			if (active_code == ATK_SPECIAL_U)
				movement <= `MOVE_SPECIAL_U;
			else
				movement <= '0;
		end
	end

endmodule

// ==== hw/attack_coprocessor.sv ====
`timescale 1ns/1ps

module attack_coprocessor (
	input  logic              clock,
	input  logic              rst_n,
	input  attack_pkg::word_t controls,
	input  attack_pkg::word_t char1_pos,
	input  attack_pkg::word_t char1_size,
	input  attack_pkg::word_t char2_pos,
	input  attack_pkg::word_t char2_size,
	output attack_pkg::word_t attack,
	output attack_pkg::word_t knockback,
	output attack_pkg::word_t movement
);
	import attack_pkg::*;

	// Decoder to sequencer
	logic         req_valid;
	attack_code_t req_code;
	logic         req_facing;

	// Sequencer to hitbox and effects
	attack_code_t active_code;
	logic         active_facing;
	logic         strike;
	logic         hit;

	// Active hitbox
	hitbox_if hitbox_bus ();

	input_decoder i_input_decoder (
		.clock      (clock),
		.rst_n      (rst_n),
		.controls   (controls),
		.req_valid  (req_valid),
		.req_code   (req_code),
		.req_facing (req_facing)
	);

	attack_sequencer i_attack_sequencer (
		.clock         (clock),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_code      (req_code),
		.req_facing    (req_facing),
		.hit           (hit),
		.active_code   (active_code),
		.active_facing (active_facing),
		.strike        (strike),
		.attack        (attack)
	);

	hitbox_gen i_hitbox_gen (
		.char1_pos     (char1_pos),
		.char1_size    (char1_size),
		.active_code   (active_code),
		.active_facing (active_facing),
		.box           (hitbox_bus.source)
	);

	box_overlap i_box_overlap (
		.box        (hitbox_bus.check),
		.char2_pos  (char2_pos),
		.char2_size (char2_size),
		.hit        (hit)
	);

	effect_unit i_effect_unit (
		.clock       (clock),
		.rst_n       (rst_n),
		.active_code (active_code),
		.strike      (strike),
		.knockback   (knockback),
		.movement    (movement)
	);

endmodule

// ==== bench/tb_attack_coprocessor.sv ====
`timescale 1ns/1ps
`include "attack_cfg.svh"

module tb_attack_coprocessor;
	import attack_pkg::*;

	localparam int ROWS = 27;
	localparam int MAX_CYC = (`SPECIAL_CYCLES > `SMASH_CYCLES) ? `SPECIAL_CYCLES : `SMASH_CYCLES;
	// Reset, lead-in and every row at its worst length
	localparam int CYCLE_LIMIT = 8 + 4 + ROWS * (MAX_CYC + 4);

	logic  clock;
	logic  rst_n;
	word_t controls, char1_pos, char1_size, char2_pos, char2_size;
	word_t attack, knockback, movement;

	// Stimulus table
	word_t        row_ctl[ROWS];
	word_t        row_p1[ROWS];
	word_t        row_s1[ROWS];
	word_t        row_p2[ROWS];
	word_t        row_s2[ROWS];
	attack_code_t row_code[ROWS];
	logic         row_hit[ROWS];
	logic         row_rep[ROWS];
	int           n_rows = 0;

	word_t       kb_model = '0;
	logic [31:0] lfsr_q = 32'he7e9;
	int          cycles = 0;

	attack_coprocessor i_attack_coprocessor (
		.clock      (clock),
		.rst_n      (rst_n),
		.controls   (controls),
		.char1_pos  (char1_pos),
		.char1_size (char1_size),
		.char2_pos  (char2_pos),
		.char2_size (char2_size),
		.attack     (attack),
		.knockback  (knockback),
		.movement   (movement)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	// Run limit
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			fail_stop("Timeout: the rows did not finish within the cycle limit");
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_stop($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_code(input string name, input attack_code_t got,
		input attack_code_t exp);
		if (got !== exp)
			fail_stop($sformatf("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_stop($sformatf("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	// One output bit per step with taps 32 22 2 1
	function automatic word_t take_bits(input int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Smash bits ordered L R U D
	function automatic word_t ctl(input logic [3:0] smash, input logic a, input logic b,
		input logic [2:0] sx, input logic [2:0] sy, input logic face);
		word_t w;
		w = '0;
		w[23:20] = smash;
		w[16] = a;
		w[17] = b;
		w[15:13] = sx;
		w[7:5] = sy;
		w[26] = face;
		return w;
	endfunction

	// Single trigger for one attack with the stick neutral unless tilted
	function automatic word_t ctl_for(input attack_code_t code, input logic face);
		case (code)
			ATK_SMASH_L:   return ctl(4'b1000, 0, 0, 3'd2, 3'd2, face);
			ATK_SMASH_R:   return ctl(4'b0100, 0, 0, 3'd2, 3'd2, face);
			ATK_SMASH_U:   return ctl(4'b0010, 0, 0, 3'd2, 3'd2, face);
			ATK_SMASH_D:   return ctl(4'b0001, 0, 0, 3'd2, 3'd2, face);
			ATK_JAB:       return ctl(4'b0000, 1, 0, 3'd2, 3'd2, face);
			ATK_SPECIAL_U: return ctl(4'b0000, 0, 1, 3'd2, 3'd7, face);
			ATK_SPECIAL_D: return ctl(4'b0000, 0, 1, 3'd2, 3'd0, face);
			ATK_SPECIAL_L: return ctl(4'b0000, 0, 1, 3'd0, 3'd2, face);
			ATK_SPECIAL_R: return ctl(4'b0000, 0, 1, 3'd7, 3'd2, face);
			default:       return ctl(4'b0000, 0, 1, 3'd2, 3'd2, face);
		endcase
	endfunction

	function automatic int duration(input attack_code_t code);
		if (code >= ATK_SMASH_U && code <= ATK_SMASH_R)
			return `SMASH_CYCLES;
		if (code == ATK_JAB)
			return `JAB_CYCLES;
		return `SPECIAL_CYCLES;
	endfunction

	// Lowest set status bit among 1 to 10 or F when several are set
	function automatic attack_code_t status_code(input word_t w);
		attack_code_t c;
		c = '0;
		for (int i = 1; i <= 10; i++)
			if (w[i])
				c = (c == '0) ? attack_code_t'(i) : 4'hF;
		return c;
	endfunction

	// Hitbox beside the attacker then half-open overlap without wrap
	function automatic logic model_hit(input attack_code_t code, input logic face,
		input word_t p1, input word_t s1, input word_t p2, input word_t s2);
		int px, py, wd, ht, hw, hh, bx, by;
		int ox, oy, ow, oh;
		int dir;
		px = p1[31:16];
		py = p1[15:0];
		wd = s1[31:16];
		ht = s1[15:0];
		ox = p2[31:16];
		oy = p2[15:0];
		ow = s2[31:16];
		oh = s2[15:0];
		hw = wd / 2;
		hh = ht / 2;
		// 0 left, 1 right, 2 up, 3 down
		case (code)
			ATK_SMASH_L, ATK_SPECIAL_L: dir = 0;
			ATK_SMASH_R, ATK_SPECIAL_R: dir = 1;
			ATK_SMASH_U, ATK_SPECIAL_U: dir = 2;
			ATK_SMASH_D, ATK_SPECIAL_D: dir = 3;
			default: dir = face ? 1 : 0;
		endcase
		case (dir)
			0: begin
				bx = px - hw;
				by = py + hh / 2;
			end
			1: begin
				bx = px + wd;
				by = py + hh / 2;
			end
			2: begin
				bx = px + hw / 2;
				by = py + ht;
			end
			default: begin
				bx = px + hw / 2;
				by = py - hh / 2;
			end
		endcase
		// Origin wraps at 16 bits
		bx = bx & 32'hFFFF;
		by = by & 32'hFFFF;
		return (bx < ox + ow) && (ox < bx + hw) && (by < oy + oh) && (oy < by + hh);
	endfunction

	task automatic add_row(input word_t c, input word_t p1, input word_t s1, input word_t p2,
		input word_t s2, input attack_code_t code, input logic rep);
		row_ctl[n_rows]  = c;
		row_p1[n_rows]   = p1;
		row_s1[n_rows]   = s1;
		row_p2[n_rows]   = p2;
		row_s2[n_rows]   = s2;
		row_code[n_rows] = code;
		row_rep[n_rows]  = rep;
		row_hit[n_rows]  = model_hit(code, c[26], p1, s1, p2, s2);
		n_rows++;
	endtask

	task automatic build_table();
		word_t p1, s1, p2, s2;
		attack_code_t rc;
		logic face;
		// Attacker at (100,100) sized 40 by 60
		p1 = 32'h0064_0064;
		s1 = 32'h0028_003C;
		// Single triggers with a large opponent for hits and a far one for misses
		add_row(ctl_for(ATK_SMASH_L, 0), p1, s1, 32'h0032_0032, 32'h0096_0096, ATK_SMASH_L, 0);
		add_row(ctl_for(ATK_SMASH_R, 0), p1, s1, 32'h0032_0032, 32'h0096_0096, ATK_SMASH_R, 0);
		// Opponent starts right at the hitbox's far Y edge
		add_row(ctl_for(ATK_SMASH_U, 0), p1, s1, 32'h006E_00BE, 32'h0010_0010, ATK_SMASH_U, 0);
		add_row(ctl_for(ATK_SMASH_D, 0), p1, s1, 32'h0032_0032, 32'h0096_0096, ATK_SMASH_D, 0);
		add_row(ctl_for(ATK_JAB, 1), p1, s1, 32'h0032_0032, 32'h0096_0096, ATK_JAB, 0);
		add_row(ctl_for(ATK_JAB, 0), p1, s1, 32'h012C_012C, 32'h000A_000A, ATK_JAB, 0);
		add_row(ctl_for(ATK_SPECIAL_N, 1), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_N, 0);
		add_row(ctl_for(ATK_SPECIAL_L, 0), p1, s1, 32'h012C_012C, 32'h000A_000A,
			ATK_SPECIAL_L, 0);
		add_row(ctl_for(ATK_SPECIAL_R, 1), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_R, 0);
		add_row(ctl_for(ATK_SPECIAL_U, 0), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_U, 0);
		add_row(ctl_for(ATK_SPECIAL_D, 0), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_D, 0);
		// Several triggers at once with some re-pulsed mid attack
		add_row(ctl(4'b1111, 1, 1, 3'd0, 3'd7, 1), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SMASH_L, 1);
		add_row(ctl(4'b0111, 1, 1, 3'd0, 3'd7, 1), p1, s1, 32'h012C_012C, 32'h000A_000A,
			ATK_SMASH_R, 0);
		add_row(ctl(4'b0011, 1, 0, 3'd2, 3'd2, 0), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SMASH_U, 1);
		add_row(ctl(4'b0000, 1, 1, 3'd0, 3'd7, 0), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_JAB, 1);
		add_row(ctl(4'b0000, 0, 1, 3'd0, 3'd7, 1), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_L, 0);
		add_row(ctl(4'b0000, 0, 1, 3'd7, 3'd0, 0), p1, s1, 32'h0032_0032, 32'h0096_0096,
			ATK_SPECIAL_R, 0);
		// Random rows use small boxes in a 256 square so some land
		while (n_rows < ROWS) begin
			rc = attack_code_t'(take_bits(4) % 10 + 1);
			face = (take_bits(1) != '0);
			p1[31:16] = coord_t'(take_bits(8));
			p1[15:0] = coord_t'(take_bits(8));
			s1[31:16] = coord_t'(take_bits(6) + 8);
			s1[15:0] = coord_t'(take_bits(6) + 8);
			p2[31:16] = coord_t'(take_bits(8));
			p2[15:0] = coord_t'(take_bits(8));
			s2[31:16] = coord_t'(take_bits(6) + 8);
			s2[15:0] = coord_t'(take_bits(6) + 8);
			add_row(ctl_for(rc, face), p1, s1, p2, s2, rc, 0);
		end
	endtask

	function automatic word_t kb_value(input attack_code_t code);
		case (code)
			ATK_SMASH_U: return `KB_SMASH_U;
			ATK_SMASH_D: return `KB_SMASH_D;
			ATK_SMASH_L: return `KB_SMASH_L;
			default:     return `KB_SMASH_R;
		endcase
	endfunction

	// Pulse, follow the active window, then the recovery cycle
	task automatic run_row(input int r);
		int    count;
		word_t exp_attack;
		word_t exp_move;
		word_t kb_before;
		controls   = row_ctl[r];
		char1_pos  = row_p1[r];
		char1_size = row_s1[r];
		char2_pos  = row_p2[r];
		char2_size = row_s2[r];
		@(posedge clock);
		#1;
		controls = '0;
		// Only the decoder edge so nothing is active yet
		check_word("attack", attack, '0);
		@(posedge clock);
		#1;
		exp_attack = (word_t'(1) << 11) | (word_t'(1) << row_code[r]) | word_t'(row_hit[r]);
		kb_before = kb_model;
		if (row_code[r] <= ATK_SMASH_R && row_hit[r])
			kb_model = kb_value(row_code[r]);
		count = 0;
		while (attack[11]) begin
			check_code("attack code", status_code(attack), row_code[r]);
			check_word("attack", attack, exp_attack);
			// First strike lands in knockback one cycle later
			check_word("knockback", knockback, (count == 0) ? kb_before : kb_model);
			exp_move = (row_code[r] == ATK_SPECIAL_U && count > 0) ? `MOVE_SPECIAL_U : '0;
			check_word("movement", movement, exp_move);
			if (row_rep[r] && count == 2)
				controls = row_ctl[r];
			if (count == 3)
				controls = '0;
			count++;
			@(posedge clock);
			#1;
		end
		check_count("active cycles", count, duration(row_code[r]));
		check_word("attack", attack, '0);
		check_word("knockback", knockback, kb_model);
		exp_move = (row_code[r] == ATK_SPECIAL_U) ? `MOVE_SPECIAL_U : '0;
		check_word("movement", movement, exp_move);
		@(posedge clock);
		#1;
		check_word("attack", attack, '0);
		check_word("movement", movement, '0);
	endtask

	initial begin
		rst_n      = 1'b0;
		controls   = '0;
		char1_pos  = '0;
		char1_size = '0;
		char2_pos  = '0;
		char2_size = '0;
		build_table();
		repeat (8) @(posedge clock);
		#1;
		rst_n = 1'b1;
		check_word("attack", attack, '0);
		check_word("knockback", knockback, '0);
		check_word("movement", movement, '0);
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
common/attack_pkg.sv
common/hitbox_if.sv
hw/input_decoder.sv
attack/attack_sequencer.sv
attack/hitbox_gen.sv
attack/box_overlap.sv
hw/effect_unit.sv
hw/attack_coprocessor.sv
bench/tb_attack_coprocessor.sv
